// ==== hdl/rv_isa_pkg.sv ====
// RV32 instruction set definitions for the core
// Field positions, opcode and funct values, and the decoded operation type

`default_nettype none

package rv_isa_pkg;

  // --------------------------------------------------------------------------
  // Instruction field positions
  // --------------------------------------------------------------------------

  localparam int OPC_LSB = 0;
  localparam int OPC_W   = 7;
  localparam int RD_LSB  = 7;
  localparam int F3_LSB  = 12;
  localparam int F3_W    = 3;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int F7_LSB  = 25;
  localparam int F7_W    = 7;

  // I-type immediate sits in the top 12 bits
  localparam int IMM_LSB = 20;
  localparam int IMM_W   = 12;

  // --------------------------------------------------------------------------
  // Opcode and funct values
  // --------------------------------------------------------------------------

  localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [OPC_W-1:0] OPC_OP     = 7'b011_0011;

  // ADDI, ADD and MUL all use funct3 000
  localparam logic [F3_W-1:0]  F3_ADD     = 3'b000;
  localparam logic [F7_W-1:0]  F7_ADD     = 7'b000_0000;
  // M extension marker
  localparam logic [F7_W-1:0]  F7_MUL     = 7'b000_0001;

  // Operation carried from decode to execute
  typedef enum logic [1:0] {
    op_addi,
    op_add,
    op_mul,
    op_illegal
  } rv_op_e;

endpackage

`default_nettype wire

// ==== hdl/core_cfg_pkg.sv ====
// Core-wide configuration constants
// Reset pc, data width and register address width

`default_nettype none

package core_cfg_pkg;

  // Data and address width
  localparam int XLEN   = 32;

  // 32 architectural registers
  localparam int REG_AW = 5;

  // First fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0200;

endpackage

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
// Fetch stage
// Four-phase req/ack fetch from instruction memory into a one-entry
// hold buffer that decode drains

`default_nettype none
`timescale 1ns/10ps

module fetch_stage (
  input  logic                          clk,
  input  logic                          reset,
  // Instruction memory
  output logic                          imem_req,
  output logic [core_cfg_pkg::XLEN-1:0] imem_addr,
  input  logic                          imem_ack,
  input  logic [core_cfg_pkg::XLEN-1:0] imem_data,
  // To decode
  output logic                          f_valid,
  output logic [core_cfg_pkg::XLEN-1:0] f_pc,
  output logic [core_cfg_pkg::XLEN-1:0] f_inst,
  input  logic                          stall
);

  import core_cfg_pkg::*;

  typedef enum logic [1:0] {
    idle,
    wait_ack,
    wait_release
  } fetch_state_e;

  fetch_state_e    state;
  logic [XLEN-1:0] pc;

  // Request held high for the whole wait_ack phase
  assign imem_req  = (state == wait_ack);
  // pc only moves after ack, so addr is stable under req
  assign imem_addr = pc;

  // --------------------------------------------------------------------------
  // Handshake FSM and pc
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      pc    <= RESET_PC;
    end else begin
      case (state)
        // Next request only with an empty buffer
        idle: begin
          if (!f_valid && !imem_ack) begin
            state <= wait_ack;
          end
        end
        wait_ack: begin
          if (imem_ack) begin
            state <= wait_release;
            pc    <= pc + XLEN'(4);
          end
        end
        // Memory must drop ack before the next req
        wait_release: begin
          if (!imem_ack) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Hold buffer
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      f_valid <= 1'b0;
    end else if (state == wait_ack && imem_ack) begin
      f_valid <= 1'b1;
    end else if (f_valid && !stall) begin
      // Decode took the word
      f_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (state == wait_ack && imem_ack) begin
      f_pc   <= pc;
      f_inst <= imem_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
// Decode stage
// Classifies the instruction, reads its operands from the register file
// and stalls one cycle on a dependence on the instruction it just issued

`default_nettype none
`timescale 1ns/10ps

module decode_stage (
  input  logic                            clk,
  input  logic                            reset,
  // From fetch
  input  logic                            f_valid,
  input  logic [core_cfg_pkg::XLEN-1:0]   f_pc,
  input  logic [core_cfg_pkg::XLEN-1:0]   f_inst,
  output logic                            stall,
  // Register file read ports
  output logic [core_cfg_pkg::REG_AW-1:0] rs1_addr,
  output logic [core_cfg_pkg::REG_AW-1:0] rs2_addr,
  input  logic [core_cfg_pkg::XLEN-1:0]   rs1_data,
  input  logic [core_cfg_pkg::XLEN-1:0]   rs2_data,
  // To execute
  output logic                            d_valid,
  output logic [core_cfg_pkg::XLEN-1:0]   d_pc,
  output rv_isa_pkg::rv_op_e              d_op,
  output logic [core_cfg_pkg::REG_AW-1:0] d_rd,
  output logic                            d_wen,
  output logic [core_cfg_pkg::XLEN-1:0]   d_a,
  output logic [core_cfg_pkg::XLEN-1:0]   d_b
);

  import core_cfg_pkg::*;
  import rv_isa_pkg::*;

  logic [OPC_W-1:0]  opcode;
  logic [F3_W-1:0]   funct3;
  logic [F7_W-1:0]   funct7;
  logic [REG_AW-1:0] rd;
  logic [XLEN-1:0]   imm;
  rv_op_e            op;
  logic              uses_rs1;
  logic              uses_rs2;
  logic              accept;

  // --------------------------------------------------------------------------
  // Field extraction
  // --------------------------------------------------------------------------

  assign opcode   = f_inst[OPC_LSB +: OPC_W];
  assign funct3   = f_inst[F3_LSB +: F3_W];
  assign funct7   = f_inst[F7_LSB +: F7_W];
  assign rd       = f_inst[RD_LSB +: REG_AW];
  assign rs1_addr = f_inst[RS1_LSB +: REG_AW];
  assign rs2_addr = f_inst[RS2_LSB +: REG_AW];

  // Sign-extended I-type immediate
  assign imm = {{(XLEN-IMM_W){f_inst[IMM_LSB+IMM_W-1]}}, f_inst[IMM_LSB +: IMM_W]};

  // Anything outside the three supported words is illegal
  always_comb begin
    if (opcode == OPC_OP_IMM && funct3 == F3_ADD) begin
      op = op_addi;
    end else if (opcode == OPC_OP && funct3 == F3_ADD && funct7 == F7_ADD) begin
      op = op_add;
    end else if (opcode == OPC_OP && funct3 == F3_ADD && funct7 == F7_MUL) begin
      op = op_mul;
    end else begin
      op = op_illegal;
    end
  end

  assign uses_rs1 = (op != op_illegal);
  assign uses_rs2 = (op == op_add) || (op == op_mul);

  // --------------------------------------------------------------------------
  // Hazard check against the output register
  // --------------------------------------------------------------------------

  // d_wen already excludes rd of x0
  // Older producers are covered by the register file write-through
  assign stall = f_valid && d_valid && d_wen &&
                 ((uses_rs1 && rs1_addr == d_rd) || (uses_rs2 && rs2_addr == d_rd));

  assign accept = f_valid && !stall;

  // Bubble on stall
  always_ff @(posedge clk) begin
    if (reset) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      d_pc  <= f_pc;
      d_op  <= op;
      d_rd  <= rd;
      d_wen <= (op != op_illegal) && (rd != '0);
      d_a   <= rs1_data;
      // Immediate replaces rs2 for ADDI
      d_b   <= (op == op_addi) ? imm : rs2_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
// Integer register file
// 32 x 32 bits, two combinational read ports, one write port
// Reads see a same-cycle write; x0 reads as zero

`default_nettype none
`timescale 1ns/10ps

module reg_file (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [core_cfg_pkg::REG_AW-1:0] rs1_addr,
  input  logic [core_cfg_pkg::REG_AW-1:0] rs2_addr,
  output logic [core_cfg_pkg::XLEN-1:0]   rs1_data,
  output logic [core_cfg_pkg::XLEN-1:0]   rs2_data,
  input  logic                            w_en,
  input  logic [core_cfg_pkg::REG_AW-1:0] w_addr,
  input  logic [core_cfg_pkg::XLEN-1:0]   w_data
);

  import core_cfg_pkg::*;

  logic [XLEN-1:0] regs [2**REG_AW];

  // Architectural state starts at zero
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (w_en && w_addr != '0) begin
      regs[w_addr] <= w_data;
    end
  end

  // Write-through for the instruction currently in writeback
  assign rs1_data = (rs1_addr == '0)                ? '0     :
                    (w_en && w_addr == rs1_addr)    ? w_data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0)                ? '0     :
                    (w_en && w_addr == rs2_addr)    ? w_data : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
// Execute stage
// Adder and multiplier for ADDI, ADD and MUL, result registered

`default_nettype none
`timescale 1ns/10ps

module execute_stage (
  input  logic                            clk,
  input  logic                            reset,
  // From decode
  input  logic                            d_valid,
  input  logic [core_cfg_pkg::XLEN-1:0]   d_pc,
  input  rv_isa_pkg::rv_op_e              d_op,
  input  logic [core_cfg_pkg::REG_AW-1:0] d_rd,
  input  logic                            d_wen,
  input  logic [core_cfg_pkg::XLEN-1:0]   d_a,
  input  logic [core_cfg_pkg::XLEN-1:0]   d_b,
  // To writeback
  output logic                            x_valid,
  output logic [core_cfg_pkg::XLEN-1:0]   x_pc,
  output logic [core_cfg_pkg::REG_AW-1:0] x_rd,
  output logic                            x_wen,
  output logic [core_cfg_pkg::XLEN-1:0]   x_result
);

  import core_cfg_pkg::*;
  import rv_isa_pkg::*;

  logic [XLEN-1:0] alu_result;

  always_comb begin
    case (d_op)
      op_addi, op_add: alu_result = d_a + d_b;
      // 32-bit context keeps the low half, same for signed and unsigned
      op_mul:          alu_result = d_a * d_b;
      default:         alu_result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      x_valid <= 1'b0;
    end else begin
      x_valid <= d_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (d_valid) begin
      x_pc     <= d_pc;
      x_rd     <= d_rd;
      x_wen    <= d_wen;
      x_result <= alu_result;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/writeback_stage.sv ====
// Writeback stage
// Drives the register file write and registers the retirement trace

`default_nettype none
`timescale 1ns/10ps

module writeback_stage (
  input  logic                            clk,
  input  logic                            reset,
  // From execute
  input  logic                            x_valid,
  input  logic [core_cfg_pkg::XLEN-1:0]   x_pc,
  input  logic [core_cfg_pkg::REG_AW-1:0] x_rd,
  input  logic                            x_wen,
  input  logic [core_cfg_pkg::XLEN-1:0]   x_result,
  // Register file write port
  output logic                            w_en,
  output logic [core_cfg_pkg::REG_AW-1:0] w_addr,
  output logic [core_cfg_pkg::XLEN-1:0]   w_data,
  // Retirement trace
  output logic                            trace_valid,
  output logic [core_cfg_pkg::XLEN-1:0]   trace_pc,
  output logic [core_cfg_pkg::REG_AW-1:0] trace_waddr,
  output logic [core_cfg_pkg::XLEN-1:0]   trace_wdata,
  output logic                            trace_wen
);

  import core_cfg_pkg::*;

  // Write lands in the same cycle x_valid is high
  assign w_en   = x_valid && x_wen && (x_rd != REG_AW'(0));
  assign w_addr = x_rd;
  assign w_data = x_result;

  // One-cycle notify pulse per retired instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= x_valid;
    end
  end

  // rd and result shown even when nothing is written
  always_ff @(posedge clk) begin
    if (x_valid) begin
      trace_pc    <= x_pc;
      trace_waddr <= x_rd;
      trace_wdata <= x_result;
      trace_wen   <= x_wen;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/blimp_core.sv ====
// Blimp RV32 core top level
// Fetch, decode, execute and writeback around a shared register file

`default_nettype none
`timescale 1ns/10ps

module blimp_core (
  input  logic                            clk,
  input  logic                            reset,
  // Instruction memory
  output logic                            imem_req,
  output logic [core_cfg_pkg::XLEN-1:0]   imem_addr,
  input  logic                            imem_ack,
  input  logic [core_cfg_pkg::XLEN-1:0]   imem_data,
  // Retirement trace
  output logic                            trace_valid,
  output logic [core_cfg_pkg::XLEN-1:0]   trace_pc,
  output logic [core_cfg_pkg::REG_AW-1:0] trace_waddr,
  output logic [core_cfg_pkg::XLEN-1:0]   trace_wdata,
  output logic                            trace_wen
);

  import core_cfg_pkg::*;
  import rv_isa_pkg::*;

  // --------------------------------------------------------------------------
  // Stage interconnect
  // --------------------------------------------------------------------------

  // Fetch to decode
  logic              f_valid;
  logic [XLEN-1:0]   f_pc;
  logic [XLEN-1:0]   f_inst;
  logic              stall;

  // Decode and register file
  logic [REG_AW-1:0] rs1_addr;
  logic [REG_AW-1:0] rs2_addr;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;

  // Decode to execute
  logic              d_valid;
  logic [XLEN-1:0]   d_pc;
  rv_op_e            d_op;
  logic [REG_AW-1:0] d_rd;
  logic              d_wen;
  logic [XLEN-1:0]   d_a;
  logic [XLEN-1:0]   d_b;

  // Execute to writeback
  logic              x_valid;
  logic [XLEN-1:0]   x_pc;
  logic [REG_AW-1:0] x_rd;
  logic              x_wen;
  logic [XLEN-1:0]   x_result;

  // Writeback to register file
  logic              w_en;
  logic [REG_AW-1:0] w_addr;
  logic [XLEN-1:0]   w_data;

  // --------------------------------------------------------------------------
  // Stages
  // --------------------------------------------------------------------------

  fetch_stage u_fetch (
    .clk       (clk),
    .reset     (reset),
    .imem_req  (imem_req),
    .imem_addr (imem_addr),
    .imem_ack  (imem_ack),
    .imem_data (imem_data),
    .f_valid   (f_valid),
    .f_pc      (f_pc),
    .f_inst    (f_inst),
    .stall     (stall)
  );

  decode_stage u_decode (
    .clk      (clk),
    .reset    (reset),
    .f_valid  (f_valid),
    .f_pc     (f_pc),
    .f_inst   (f_inst),
    .stall    (stall),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .d_valid  (d_valid),
    .d_pc     (d_pc),
    .d_op     (d_op),
    .d_rd     (d_rd),
    .d_wen    (d_wen),
    .d_a      (d_a),
    .d_b      (d_b)
  );

  // Written from writeback, read from decode
  reg_file u_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .w_en     (w_en),
    .w_addr   (w_addr),
    .w_data   (w_data)
  );

  execute_stage u_execute (
    .clk      (clk),
    .reset    (reset),
    .d_valid  (d_valid),
    .d_pc     (d_pc),
    .d_op     (d_op),
    .d_rd     (d_rd),
    .d_wen    (d_wen),
    .d_a      (d_a),
    .d_b      (d_b),
    .x_valid  (x_valid),
    .x_pc     (x_pc),
    .x_rd     (x_rd),
    .x_wen    (x_wen),
    .x_result (x_result)
  );

  writeback_stage u_writeback (
    .clk         (clk),
    .reset       (reset),
    .x_valid     (x_valid),
    .x_pc        (x_pc),
    .x_rd        (x_rd),
    .x_wen       (x_wen),
    .x_result    (x_result),
    .w_en        (w_en),
    .w_addr      (w_addr),
    .w_data      (w_data),
    .trace_valid (trace_valid),
    .trace_pc    (trace_pc),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata),
    .trace_wen   (trace_wen)
  );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
// Testbench clock and reset generator
// 40 ns clock, reset held high for the first 10 rising edges

`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  localparam time PERIOD       = 40ns;
  localparam int  RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Released on a falling edge, away from the DUT sampling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== sim/core_assertions.sv ====
// Protocol checks bound into the core
// Four-phase fetch handshake and trace port behavior around reset

`default_nettype none
`timescale 1ns/10ps

module core_assertions (
  input logic                          clk,
  input logic                          reset,
  input logic                          imem_req,
  input logic [core_cfg_pkg::XLEN-1:0] imem_addr,
  input logic                          imem_ack,
  input logic                          trace_valid
);

  // Read by the testbench at the end of the run
  int failures = 0;

  // Address held for as long as the request stays up
  addr_stable_under_req: assert property (@(posedge clk) disable iff (reset)
    imem_req && $past(imem_req) |-> $stable(imem_addr))
  else begin
    $error("imem_addr changed while imem_req was high");
    failures++;
  end

  // Next request only after the memory released ack
  // Ack as seen on the edge that raised req
  no_req_rise_with_ack: assert property (@(posedge clk) disable iff (reset)
    $rose(imem_req) |-> !$past(imem_ack))
  else begin
    $error("imem_req rose while imem_ack was still high");
    failures++;
  end

  // Trace port quiet once reset has been seen
  no_trace_in_reset: assert property (@(posedge clk)
    reset |=> !trace_valid)
  else begin
    $error("trace_valid high during reset");
    failures++;
  end

endmodule

bind blimp_core core_assertions u_core_assertions (
  .clk         (clk),
  .reset       (reset),
  .imem_req    (imem_req),
  .imem_addr   (imem_addr),
  .imem_ack    (imem_ack),
  .trace_valid (trace_valid)
);

`default_nettype wire

// ==== sim/core_tb.sv ====
// Core testbench
// Loads the program image and expected traces, models the instruction
// memory with random handshake delays, and checks every retirement trace

`default_nettype none
`timescale 1ns/10ps

module core_tb;

  import core_cfg_pkg::*;

  localparam int          RESET_CYCLES    = 10;
  localparam int          CYCLES_PER_INST = 40;
  localparam int          IMEM_WORDS      = 64;
  localparam int unsigned SEED            = 44516;
  localparam string       STIM_FILE       = "sim/core_stimulus.txt";

  typedef struct {
    string             name;
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] waddr;
    logic [XLEN-1:0]   wdata;
    logic              wen;
  } trace_rec_t;

  logic              clk;
  logic              reset;
  logic              imem_req;
  logic [XLEN-1:0]   imem_addr;
  logic              imem_ack;
  logic [XLEN-1:0]   imem_data;
  logic              trace_valid;
  logic [XLEN-1:0]   trace_pc;
  logic [REG_AW-1:0] trace_waddr;
  logic [XLEN-1:0]   trace_wdata;
  logic              trace_wen;

  logic [XLEN-1:0] imem_words [IMEM_WORDS];
  trace_rec_t      expected_q [$];
  int              errors        = 0;
  int              checks        = 0;
  int              cycle_count   = 0;
  int              timeout_limit = 0;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  blimp_core dut0 (
    .clk         (clk),
    .reset       (reset),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .imem_ack    (imem_ack),
    .imem_data   (imem_data),
    .trace_valid (trace_valid),
    .trace_pc    (trace_pc),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata),
    .trace_wen   (trace_wen)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // --------------------------------------------------------------------------
  // Stimulus loading
  // --------------------------------------------------------------------------

  task automatic load_stimulus();
    int          fd;
    int          idx;
    string       line;
    string       tag;
    logic [31:0] addr;
    logic [31:0] word;
    trace_rec_t  rec;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem_words[i] = '0;
    end
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", STIM_FILE);
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) continue;
      if ($sscanf(line, "%s", tag) != 1) continue;
      if (tag == "M" && $sscanf(line, "%s %h %h", tag, addr, word) == 3) begin
        idx = (addr - RESET_PC) >> 2;
        if (addr < RESET_PC || addr[1:0] != 2'b00 || idx >= IMEM_WORDS) begin
          $display("program word at address %h lies outside the memory model", addr);
          errors++;
        end else begin
          imem_words[idx] = word;
        end
      end else if (tag == "T") begin
        if ($sscanf(line, "%s %s %h %d %h %d", tag, rec.name, rec.pc, rec.waddr,
                    rec.wdata, rec.wen) == 6) begin
          expected_q.push_back(rec);
        end
      end
    end
    $fclose(fd);
  endtask

  // Unmapped words read as zero, which decodes as illegal
  function automatic logic [XLEN-1:0] read_word(input logic [XLEN-1:0] addr);
    int idx;
    idx = (addr - RESET_PC) >> 2;
    if (addr < RESET_PC || idx >= IMEM_WORDS) begin
      return '0;
    end
    return imem_words[idx];
  endfunction

  // --------------------------------------------------------------------------
  // Instruction memory, four-phase slave
  // --------------------------------------------------------------------------

  initial begin : imem_model
    int unsigned delay;
    void'($urandom(SEED));
    imem_ack  = 1'b0;
    imem_data = '0;
    forever begin
      @(negedge clk);
      if (imem_req && !imem_ack) begin
        delay = $urandom % 4;
        repeat (delay) @(negedge clk);
        imem_data = read_word(imem_addr);
        imem_ack  = 1'b1;
        // Hold ack until the fetch stage drops req
        while (imem_req) @(negedge clk);
        delay = $urandom % 4;
        repeat (delay) @(negedge clk);
        imem_ack = 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Trace checking
  // --------------------------------------------------------------------------

  task automatic check_trace();
    trace_rec_t expected;
    if (expected_q.size() == 0) begin
      $display("unexpected extra trace at pc %h after the last expected one", trace_pc);
      errors++;
      return;
    end
    expected = expected_q.pop_front();
    checks++;
    assert (trace_pc === expected.pc) else begin
      $display("mismatch %s pc: expected %h, actual %h", expected.name, expected.pc, trace_pc);
      errors++;
    end
    assert (trace_waddr === expected.waddr) else begin
      $display("mismatch %s waddr: expected %0d, actual %0d", expected.name,
               expected.waddr, trace_waddr);
      errors++;
    end
    assert (trace_wdata === expected.wdata) else begin
      $display("mismatch %s wdata: expected %h, actual %h", expected.name,
               expected.wdata, trace_wdata);
      errors++;
    end
    assert (trace_wen === expected.wen) else begin
      $display("mismatch %s wen: expected %b, actual %b", expected.name,
               expected.wen, trace_wen);
      errors++;
    end
  endtask

  initial begin : main
    int assert_failures;
    load_stimulus();
    if (expected_q.size() == 0) begin
      $display("no expected traces found in the stimulus file");
      errors++;
    end
    timeout_limit = CYCLES_PER_INST * expected_q.size() + RESET_CYCLES;
    @(negedge clk);
    while (reset) @(negedge clk);
    // Outputs are registered, so sample them on the falling edge
    while (expected_q.size() > 0 && cycle_count < timeout_limit) begin
      @(negedge clk);
      if (trace_valid) begin
        check_trace();
      end
    end
    if (expected_q.size() > 0) begin
      $display("timeout after %0d cycles with %0d expected traces still missing",
               cycle_count, expected_q.size());
      errors++;
    end
    assert_failures = dut0.u_core_assertions.failures;
    errors += assert_failures;
    $display("traces checked %0d, errors %0d, assertion failures %0d",
             checks, errors, assert_failures);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/core_stimulus.txt ====
# M <address hex> <instruction word hex>
# T <test name> <pc hex> <waddr decimal> <wdata hex> <wen>
M 00000200 00500093
M 00000204 ffd00113
M 00000208 7ff08193
M 0000020c 00208233
M 00000210 004202b3
M 00000214 00428333
M 00000218 005303b3
M 0000021c 02238433
M 00000220 7ff00493
M 00000224 02948533
M 00000228 02a505b3
M 0000022c 02210633
M 00000230 06408013
M 00000234 001006b3
M 00000238 402087b3
M 0000023c 00178793
T addi_pos        00000200  1 00000005 1
T addi_neg        00000204  2 fffffffd 1
T addi_max_imm    00000208  3 00000804 1
T add_pos_neg     0000020c  4 00000002 1
T add_chain_a     00000210  5 00000004 1
T add_chain_b     00000214  6 00000006 1
T add_chain_c     00000218  7 0000000a 1
T mul_negative    0000021c  8 ffffffe2 1
T addi_setup      00000220  9 000007ff 1
T mul_square      00000224 10 003ff001 1
T mul_overflow    00000228 11 017fe001 1
T mul_neg_neg     0000022c 12 00000009 1
T write_x0        00000230  0 00000069 0
T read_x0         00000234 13 00000005 1
T illegal_sub     00000238 15 00000000 0
T after_illegal   0000023c 15 00000001 1

// ==== sim.f ====
hdl/rv_isa_pkg.sv
hdl/core_cfg_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/blimp_core.sv
sim/tb_clock_gen.sv
sim/core_assertions.sv
sim/core_tb.sv

// ==== Bender.yml ====
package:
  name: blimp_core

sources:
  # RTL, packages first
  - files:
      - hdl/rv_isa_pkg.sv
      - hdl/core_cfg_pkg.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/reg_file.sv
      - hdl/execute_stage.sv
      - hdl/writeback_stage.sv
      - hdl/blimp_core.sv
  # Testbench
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/core_assertions.sv
      - sim/core_tb.sv
